//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Sizes
    localparam int data_width      = 16;
    localparam int reg_addr_width  = 3;
    localparam int num_regs        = 8;
    localparam int dmem_words      = 64;
    localparam int dmem_addr_width = 6;

    // Codes 12 to 15 decode as nop
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_slt  = 4'd5,
        op_addi = 4'd6,
        op_lw   = 4'd7,
        op_sw   = 4'd8,
        op_beq  = 4'd9,
        op_bne  = 4'd10,
        op_jmp  = 4'd11
    } op_t;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_t;

    typedef enum logic [1:0] {br_none, br_eq, br_ne, br_jump} branch_t;

    typedef enum logic [1:0] {fwd_reg, fwd_mem_wb, fwd_ex_mem} fwd_sel_t;

    // rd sits in the upper three bits of imm
    typedef struct packed {
        op_t                       op;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [5:0]                imm;
    } instr_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src;
        logic    reg_dst;
        alu_op_t alu_op;
        branch_t branch;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] rd;
        logic [data_width-1:0]     read_data_1;
        logic [data_width-1:0]     read_data_2;
        logic [data_width-1:0]     immediate;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                      ctrl;
        logic [reg_addr_width-1:0]  dest;
        logic [data_width-1:0]      alu_result;
        logic                       compare;
        logic [data_width-1:0]      store_data;
        logic [dmem_addr_width-1:0] mem_address;
        logic [data_width-1:0]      target;
    } ex_mem_t;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_to_reg;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     alu_result;
        logic [data_width-1:0]     read_data;
    } mem_wb_t;

    // Retired register write
    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     data;
    } wb_t;

endpackage

`default_nettype wire

//--- source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  cpu_pkg::op_t   opcode,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_add, op_sub, op_and, op_or, op_slt: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (opcode)
                    op_sub:  ctrl.alu_op = alu_sub;
                    op_and:  ctrl.alu_op = alu_and;
                    op_or:   ctrl.alu_op = alu_or;
                    op_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            // Address comes straight from rs, ALU result unused
            op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_sw:   ctrl.mem_write = 1'b1;
            op_beq:  ctrl.branch = br_eq;
            op_bne:  ctrl.branch = br_ne;
            op_jmp:  ctrl.branch = br_jump;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               write,
    input  logic [cpu_pkg::reg_addr_width-1:0] write_address,
    input  logic [cpu_pkg::data_width-1:0]     write_data,
    input  logic [cpu_pkg::reg_addr_width-1:0] read_address_1,
    input  logic [cpu_pkg::reg_addr_width-1:0] read_address_2,
    output logic [cpu_pkg::data_width-1:0]     read_data_1,
    output logic [cpu_pkg::data_width-1:0]     read_data_2
);
    import cpu_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[write_address] <= write_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign read_data_1 = (write && write_address == read_address_1) ? write_data
                                                                     : regs[read_address_1];
    assign read_data_2 = (write && write_address == read_address_2) ? write_data
                                                                     : regs[read_address_2];

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_width-1:0] if_id_rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] if_id_rt,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_ex_rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_ex_rt,
    input  logic                               id_ex_load,
    input  logic [cpu_pkg::reg_addr_width-1:0] ex_mem_dest,
    input  logic [cpu_pkg::reg_addr_width-1:0] mem_wb_dest,
    input  logic                               ex_mem_reg_write,
    input  logic                               mem_wb_reg_write,
    output cpu_pkg::fwd_sel_t                  forward_a,
    output cpu_pkg::fwd_sel_t                  forward_b,
    output logic                               stall
);
    import cpu_pkg::*;

    // Younger result wins when both stages match
    function automatic fwd_sel_t select_source(input logic [reg_addr_width-1:0] src);
        fwd_sel_t sel;
        if (ex_mem_reg_write && ex_mem_dest == src) begin
            sel = fwd_ex_mem;
        end else if (mem_wb_reg_write && mem_wb_dest == src) begin
            sel = fwd_mem_wb;
        end else begin
            sel = fwd_reg;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a = select_source(id_ex_rs);
        forward_b = select_source(id_ex_rt);
    end

    // Load data only exists after MEM, so hold the consumer one cycle
    assign stall = id_ex_load && (id_ex_rt == if_id_rs || id_ex_rt == if_id_rt);

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t               alu_op,
    input  logic [cpu_pkg::data_width-1:0] data1,
    input  logic [cpu_pkg::data_width-1:0] data2,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           compare
);
    import cpu_pkg::*;

    always_comb begin
        case (alu_op)
            alu_sub: result = data1 - data2;
            alu_and: result = data1 & data2;
            alu_or:  result = data1 | data2;
            // Unsigned compare
            alu_slt: result = {{(data_width-1){1'b0}}, data1 < data2};
            default: result = data1 + data2;
        endcase
    end

    // Equality for beq and bne
    assign compare = (data1 == data2);

endmodule

`default_nettype wire

//--- source/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                write,
    input  logic [cpu_pkg::dmem_addr_width-1:0] address,
    input  logic [cpu_pkg::data_width-1:0]      write_data,
    output logic [cpu_pkg::data_width-1:0]      read_data
);
    import cpu_pkg::*;

    logic [data_width-1:0] mem [dmem_words];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[address] <= write_data;
        end
    end

    assign read_data = mem[address];

endmodule

`default_nettype wire

//--- source/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [cpu_pkg::data_width-1:0] pc,
    input  cpu_pkg::instr_t                instruction,
    output cpu_pkg::wb_t                   wb
);
    import cpu_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    ctrl_t                     ctrl;
    logic [data_width-1:0]     read_data_1;
    logic [data_width-1:0]     read_data_2;
    fwd_sel_t                  forward_a;
    fwd_sel_t                  forward_b;
    logic                      stall;
    logic                      flush;
    logic                      ex_mem_forwardable;
    logic [data_width-1:0]     operand_a;
    logic [data_width-1:0]     operand_b;
    logic [data_width-1:0]     alu_operand_2;
    logic [data_width-1:0]     alu_result;
    logic                      compare;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     mem_read_data;
    logic [data_width-1:0]     wb_data;

    function automatic logic [data_width-1:0] forward_mux(
        input fwd_sel_t              sel,
        input logic [data_width-1:0] reg_value,
        input logic [data_width-1:0] ex_mem_value,
        input logic [data_width-1:0] mem_wb_value
    );
        case (sel)
            fwd_ex_mem: return ex_mem_value;
            fwd_mem_wb: return mem_wb_value;
            default:    return reg_value;
        endcase
    endfunction

    //////////////////////////////
    // Fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= ex_mem.target;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.instr <= instruction;
        end
    end

    //////////////////////////////
    // Decode
    control_unit u_control (.opcode(if_id.instr.op), .ctrl(ctrl));

    register_file u_regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .write         (mem_wb.reg_write),
        .write_address (mem_wb.dest),
        .write_data    (wb_data),
        .read_address_1(if_id.instr.rs),
        .read_address_2(if_id.instr.rt),
        .read_data_1   (read_data_1),
        .read_data_2   (read_data_2)
    );

    // Loads leave EX/MEM without data, so they never forward from there
    assign ex_mem_forwardable = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_to_reg;

    hazard_unit u_hazard (
        .if_id_rs        (if_id.instr.rs),
        .if_id_rt        (if_id.instr.rt),
        .id_ex_rs        (id_ex.rs),
        .id_ex_rt        (id_ex.rt),
        .id_ex_load      (id_ex.ctrl.mem_to_reg),
        .ex_mem_dest     (ex_mem.dest),
        .mem_wb_dest     (mem_wb.dest),
        .ex_mem_reg_write(ex_mem_forwardable),
        .mem_wb_reg_write(mem_wb.reg_write),
        .forward_a       (forward_a),
        .forward_b       (forward_b),
        .stall           (stall)
    );

    // Bubble on stall or flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush || stall) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl        <= if_id.valid ? ctrl : '0;
            id_ex.rs          <= if_id.instr.rs;
            id_ex.rt          <= if_id.instr.rt;
            id_ex.rd          <= if_id.instr.imm[5 -: reg_addr_width];
            id_ex.read_data_1 <= read_data_1;
            id_ex.read_data_2 <= read_data_2;
            id_ex.immediate   <= data_width'(if_id.instr.imm);
        end
    end

    //////////////////////////////
    // Execute
    assign operand_a = forward_mux(forward_a, id_ex.read_data_1, ex_mem.alu_result, wb_data);
    assign operand_b = forward_mux(forward_b, id_ex.read_data_2, ex_mem.alu_result, wb_data);
    assign alu_operand_2 = id_ex.ctrl.alu_src ? id_ex.immediate : operand_b;
    assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

    alu u_alu (
        .alu_op (id_ex.ctrl.alu_op),
        .data1  (operand_a),
        .data2  (alu_operand_2),
        .result (alu_result),
        .compare(compare)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl        <= id_ex.ctrl;
            ex_mem.dest        <= dest;
            ex_mem.alu_result  <= alu_result;
            ex_mem.compare     <= compare;
            ex_mem.store_data  <= operand_b;
            ex_mem.mem_address <= operand_a[dmem_addr_width-1:0];
            ex_mem.target      <= id_ex.immediate;
        end
    end

    //////////////////////////////
    // Memory and branch resolution
    always_comb begin
        case (ex_mem.ctrl.branch)
            br_eq:   flush = ex_mem.compare;
            br_ne:   flush = !ex_mem.compare;
            br_jump: flush = 1'b1;
            default: flush = 1'b0;
        endcase
    end

    data_memory u_dmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .write     (ex_mem.ctrl.mem_write),
        .address   (ex_mem.mem_address),
        .write_data(ex_mem.store_data),
        .read_data (mem_read_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.read_data  <= mem_read_data;
        end
    end

    //////////////////////////////
    // Write-back
    assign wb_data  = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
    assign wb.valid = mem_wb.reg_write;
    assign wb.dest  = mem_wb.dest;
    assign wb.data  = wb_data;

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input logic         clk,
    input logic         rst_n,
    input logic         stall,
    input logic         flush,
    input logic         mem_wb_reg_write,
    input cpu_pkg::wb_t wb
);
    int failures = 0;

    // MEM/WB is cleared by the first reset edge
    wb_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !wb.valid)
        else begin
            failures++;
            $error("wb.valid high while the core is held in reset");
        end

    // The bubble behind a load removes the hazard
    stall_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else begin
            failures++;
            $error("load-use stall held for two cycles in a row");
        end

    // Branch retires first, then the two bubbles from EX and ID
    flush_bubbles: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> ##2 !mem_wb_reg_write ##1 !mem_wb_reg_write)
        else begin
            failures++;
            $error("flushed instruction reached MEM/WB with a register write");
        end

endmodule

`default_nettype wire

//--- dv/cpu_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_monitor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  int                     test_id,
    input  cpu_pkg::instr_t [31:0] program_words,
    input  cpu_pkg::wb_t           wb,
    output logic                   done,
    output int                     errors
);
    import cpu_pkg::*;

    localparam int quiet_done  = 12;
    localparam int quiet_limit = 140;

    wb_t  expected [$];
    logic active;
    int   current_test;
    int   quiet;
    int   checked;
    int   err_count;

    function automatic string test_name(input int id);
        case (id)
            0:       return "arithmetic";
            1:       return "forwarding";
            2:       return "load/store";
            3:       return "branches";
            default: return "mixed";
        endcase
    endfunction

    //////////////////////////////
    // Instruction-set model
    task automatic run_model();
        logic [data_width-1:0] regs [num_regs];
        logic [data_width-1:0] dmem [dmem_words];
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        instr_t                in;
        wb_t                   w;
        int                    pc;
        expected.delete();
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = '0;
        end
        pc = 0;
        // Targets only go forward, so this always ends
        while (pc < 32) begin
            in      = program_words[pc];
            a       = regs[in.rs];
            b       = regs[in.rt];
            w.valid = 1'b1;
            w.dest  = in.imm[5:3];
            w.data  = '0;
            pc      = pc + 1;
            case (in.op)
                op_add:  w.data = a + b;
                op_sub:  w.data = a - b;
                op_and:  w.data = a & b;
                op_or:   w.data = a | b;
                op_slt:  w.data = (a < b) ? 16'd1 : 16'd0;
                op_addi: begin
                    w.dest = in.rt;
                    w.data = a + {10'd0, in.imm};
                end
                op_lw: begin
                    w.dest = in.rt;
                    w.data = dmem[a[5:0]];
                end
                op_sw: begin
                    dmem[a[5:0]] = b;
                    w.valid      = 1'b0;
                end
                op_beq: begin
                    if (a == b) begin
                        pc = int'(in.imm);
                    end
                    w.valid = 1'b0;
                end
                op_bne: begin
                    if (a != b) begin
                        pc = int'(in.imm);
                    end
                    w.valid = 1'b0;
                end
                op_jmp: begin
                    pc      = int'(in.imm);
                    w.valid = 1'b0;
                end
                default: w.valid = 1'b0;
            endcase
            if (w.valid) begin
                regs[w.dest] = w.data;
                expected.push_back(w);
            end
        end
    endtask

    task automatic check_write();
        wb_t want;
        if (expected.size() == 0) begin
            $display("Extra write to r%0d with data %h after the last expected write",
                     wb.dest, wb.data);
            err_count++;
        end else begin
            want = expected.pop_front();
            checked++;
            if (wb.dest !== want.dest) begin
                $display("FAILED wb.dest exp %h got %h", want.dest, wb.dest);
                err_count++;
            end
            if (wb.data !== want.data) begin
                $display("FAILED wb.data exp %h got %h", want.data, wb.data);
                err_count++;
            end
        end
    endtask

    task automatic finish_test();
        if (expected.size() != 0) begin
            $display("Missing %0d expected writes at the end of test %0d",
                     expected.size(), current_test);
            err_count++;
        end
        $display("Test %0d %s: %0d writes checked, %0d errors",
                 current_test, test_name(current_test), checked, err_count);
        active = 1'b0;
        done   <= 1'b1;
        errors <= err_count;
    endtask

    //////////////////////////////
    // In-order compare of retired writes
    always @(posedge clk) begin
        if (!rst_n) begin
            active = 1'b0;
            done   <= 1'b0;
        end else if (start) begin
            run_model();
            current_test = test_id;
            active       = 1'b1;
            quiet        = 0;
            checked      = 0;
            err_count    = 0;
        end else if (active) begin
            if (wb.valid) begin
                quiet = 0;
                check_write();
            end else begin
                quiet = quiet + 1;
                // Long silence means the core stopped short of the model
                if ((expected.size() == 0 && quiet >= quiet_done) || quiet >= quiet_limit) begin
                    finish_test();
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int num_tests   = 5;
    localparam int prog_len    = 32;
    localparam int cycle_limit = num_tests * (prog_len * 4 + 40);

    logic                  clk;
    logic                  rst_n;
    logic [data_width-1:0] pc;
    instr_t                instruction;
    wb_t                   wb;
    instr_t [prog_len-1:0] program_words;
    logic                  start;
    int                    test_id;
    logic                  done;
    int                    errors;
    logic [15:0]           lfsr_state;
    int                    cycle_count;
    int                    tests_failed;

    tb_clock u_clock (.clk(clk));

    cpu UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .instruction(instruction),
        .wb         (wb)
    );

    cpu_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .test_id      (test_id),
        .program_words(program_words),
        .wb           (wb),
        .done         (done),
        .errors       (errors)
    );

    bind cpu cpu_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .mem_wb_reg_write(mem_wb.reg_write),
        .wb              (wb)
    );

    //////////////////////////////
    // Stimulus generation
    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic op_t pick_op(input int test);
        logic [3:0] r;
        op_t        op;
        case (test)
            0, 1: begin
                r  = 4'(take_bits(3));
                op = (r < 4'd5) ? op_t'(r + 4'd1) : op_addi;
            end
            2: begin
                r  = 4'(take_bits(2));
                op = (r == 4'd0) ? op_addi : (r == 4'd1) ? op_sw : (r == 4'd2) ? op_lw : op_add;
            end
            3: begin
                r = 4'(take_bits(3));
                case (r)
                    4'd0, 4'd1: op = op_addi;
                    4'd2:       op = op_add;
                    4'd3, 4'd4: op = op_beq;
                    4'd5:       op = op_bne;
                    4'd6:       op = op_jmp;
                    default:    op = op_sub;
                endcase
            end
            // Unused codes included, they run as nop
            default: begin
                r  = 4'(take_bits(4));
                op = op_t'(r);
            end
        endcase
        return op;
    endfunction

    task automatic build_program(input int test);
        instr_t     in;
        logic [2:0] recent [3];
        int         target;
        recent = '{3'd0, 3'd0, 3'd0};
        for (int i = 0; i < prog_len; i++) begin
            in.op  = pick_op(test);
            in.rs  = 3'(take_bits(3));
            in.rt  = 3'(take_bits(3));
            in.imm = 6'(take_bits(6));
            // Chain operands to recent results at distances 1 to 3
            if ((test == 1 || test == 2) && take_bits(2) != 16'd0) begin
                in.rs = recent[0];
            end
            if (test == 1) begin
                in.rt = take_bits(1) != 16'd0 ? recent[2] : recent[1];
            end
            if (in.op == op_beq || in.op == op_bne || in.op == op_jmp) begin
                target = i + 1 + int'(take_bits(2));
                in.imm = 6'((target > prog_len) ? prog_len : target);
            end
            if (in.op inside {op_add, op_sub, op_and, op_or, op_slt}) begin
                recent = '{in.imm[5:3], recent[0], recent[1]};
            end else if (in.op inside {op_addi, op_lw}) begin
                recent = '{in.rt, recent[0], recent[1]};
            end
            program_words[i] = in;
        end
    endtask

    // Past the end of the program the core sees nop
    function automatic instr_t fetch_word(input logic [data_width-1:0] address);
        instr_t word;
        if (address < prog_len) begin
            word = program_words[address[4:0]];
        end else begin
            word = '0;
        end
        return word;
    endfunction

    // Refreshed on the edge that moves pc or releases reset
    always @(pc or rst_n) begin
        instruction <= fetch_word(pc);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with tests still running", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence
    initial begin
        rst_n         = 1'b0;
        instruction   = '0;
        start         = 1'b0;
        test_id       = 0;
        program_words = '0;
        lfsr_state    = 16'd40;
        cycle_count   = 0;
        tests_failed  = 0;
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            build_program(t);
            repeat (4) @(posedge clk);
            rst_n   <= 1'b1;
            test_id <= t;
            start   <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            while (!done) begin
                @(posedge clk);
            end
            if (errors != 0) begin
                tests_failed++;
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 num_tests, num_tests - tests_failed, tests_failed, UUT.u_checker.failures);
        if (tests_failed == 0 && UUT.u_checker.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/cpu_pkg.sv
source/control_unit.sv
source/register_file.sv
source/hazard_unit.sv
source/alu.sv
source/data_memory.sv
source/cpu.sv
dv/tb_clock.sv
dv/cpu_checker.sv
dv/cpu_monitor.sv
dv/cpu_tb.sv
